/* Bender.yml */
package:
  name: request_scheduler

sources:
  - sched_pkg.sv
  - request_router.sv
  - bank_queue.sv
  - bank_tracker.sv
  - command_arbiter.sv
  - request_scheduler.sv
  - target: test
    files:
      - tb_request_scheduler.sv

/* bank_queue.sv */
`timescale 1ns/1ps

module bank_queue (
    input  logic                            clk_in,
    input  logic                            rst_in,
    input  logic                            enq,
    input  logic                            deq,
    input  logic [sched_pkg::ROW_BITS-1:0]  in_row,
    input  logic [sched_pkg::COL_BITS-1:0]  in_col,
    input  logic                            in_write,
    input  logic [sched_pkg::DATA_BITS-1:0] in_data,
    output logic                            full,
    output logic                            empty,
    output logic [sched_pkg::ROW_BITS-1:0]  head_row,
    output logic [sched_pkg::COL_BITS-1:0]  head_col,
    output logic                            head_write,
    output logic [sched_pkg::DATA_BITS-1:0] head_data
);

    logic [sched_pkg::ROW_BITS-1:0]  row_mem   [sched_pkg::QUEUE_DEPTH];
    logic [sched_pkg::COL_BITS-1:0]  col_mem   [sched_pkg::QUEUE_DEPTH];
    logic                            write_mem [sched_pkg::QUEUE_DEPTH];
    logic [sched_pkg::DATA_BITS-1:0] data_mem  [sched_pkg::QUEUE_DEPTH];

    logic [sched_pkg::QPTR_BITS-1:0] wr_ptr;
    logic [sched_pkg::QPTR_BITS-1:0] rd_ptr;
    logic [sched_pkg::QPTR_BITS:0]   count; // one extra bit to tell full from empty
    logic                            push;
    logic                            pop;

    assign full  = (count == sched_pkg::QUEUE_DEPTH[sched_pkg::QPTR_BITS:0]);
    assign empty = (count == '0);

    assign push = enq && !full;
    assign pop  = deq && !empty;

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps by itself
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // entry storage
    always_ff @(posedge clk_in) begin
        if (push) begin
            row_mem[wr_ptr]   <= in_row;
            col_mem[wr_ptr]   <= in_col;
            write_mem[wr_ptr] <= in_write;
            data_mem[wr_ptr]  <= in_data;
        end
    end

    // oldest request of this bank
    assign head_row   = row_mem[rd_ptr];
    assign head_col   = col_mem[rd_ptr];
    assign head_write = write_mem[rd_ptr];
    assign head_data  = data_mem[rd_ptr];

endmodule

/* bank_tracker.sv */
`timescale 1ns/1ps

module bank_tracker (
    input  logic                                                 clk_in,
    input  logic                                                 rst_in,
    input  logic [sched_pkg::NUM_BANKS-1:0]                      act,
    input  logic [sched_pkg::NUM_BANKS-1:0]                      pre,
    input  logic [sched_pkg::ROW_BITS-1:0]                       act_row,
    output logic [sched_pkg::NUM_BANKS-1:0]                      open,
    output logic [sched_pkg::NUM_BANKS-1:0][sched_pkg::ROW_BITS-1:0] open_row,
    output logic [sched_pkg::NUM_BANKS-1:0]                      busy
);

    // remaining activate or precharge latency per bank
    logic [sched_pkg::NUM_BANKS-1:0][sched_pkg::TIMER_BITS-1:0] timer;

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            open  <= '0;
            timer <= '0;
        end else begin
            for (int b = 0; b < sched_pkg::NUM_BANKS; b++) begin
                if (act[b]) begin
                    open[b]  <= 1'b1;
                    timer[b] <= sched_pkg::ACT_LATENCY[sched_pkg::TIMER_BITS-1:0];
                end else if (pre[b]) begin
                    open[b]  <= 1'b0;
                    timer[b] <= sched_pkg::PRE_LATENCY[sched_pkg::TIMER_BITS-1:0];
                end else if (timer[b] != '0) begin
                    timer[b] <= timer[b] - 1'b1;
                end
            end
        end
    end

    // row is only meaningful while the bank is open
    always_ff @(posedge clk_in) begin
        for (int b = 0; b < sched_pkg::NUM_BANKS; b++) begin
            if (act[b]) open_row[b] <= act_row;
        end
    end

    always_comb begin
        for (int b = 0; b < sched_pkg::NUM_BANKS; b++) begin
            busy[b] = (timer[b] != '0);
        end
    end

endmodule

/* command_arbiter.sv */
`timescale 1ns/1ps

module command_arbiter (
    input  logic clk_in,
    input  logic rst_in,
    input  logic cmd_ready,
    input  logic bursting,
    input  logic [sched_pkg::NUM_BANKS-1:0]                           empty,
    input  logic [sched_pkg::NUM_BANKS-1:0][sched_pkg::ROW_BITS-1:0]  head_row,
    input  logic [sched_pkg::NUM_BANKS-1:0][sched_pkg::COL_BITS-1:0]  head_col,
    input  logic [sched_pkg::NUM_BANKS-1:0]                           head_write,
    input  logic [sched_pkg::NUM_BANKS-1:0][sched_pkg::DATA_BITS-1:0] head_data,
    input  logic [sched_pkg::NUM_BANKS-1:0]                           open,
    input  logic [sched_pkg::NUM_BANKS-1:0][sched_pkg::ROW_BITS-1:0]  open_row,
    input  logic [sched_pkg::NUM_BANKS-1:0]                           busy,
    output logic [sched_pkg::NUM_BANKS-1:0] deq,
    output logic [sched_pkg::NUM_BANKS-1:0] act,
    output logic [sched_pkg::NUM_BANKS-1:0] pre,
    output logic [sched_pkg::ROW_BITS-1:0]  act_row,
    output logic                            valid_out,
    output logic [sched_pkg::CMD_BITS-1:0]  cmd_out,
    output sched_pkg::cmd_addr_u            addr_out,
    output logic [sched_pkg::DATA_BITS-1:0] val_out
);

    logic [sched_pkg::NUM_BANKS-1:0]     ready, row_hit;
    logic [sched_pkg::NUM_BANKS-1:0]     need_rd, need_wr, need_act, need_pre;
    logic [sched_pkg::GAP_BITS-1:0]      gap_cnt; // cycles since last read or write, saturating
    logic                                gap_ok;
    logic                                pick_valid;
    logic                                col_issue;
    logic [sched_pkg::CMD_BITS-1:0]      pick_cmd;
    logic [sched_pkg::BANK_IDX_BITS-1:0] pick_bank;
    sched_pkg::cmd_addr_u                next_addr;

    function automatic logic [sched_pkg::BANK_IDX_BITS-1:0] lowest(
        input logic [sched_pkg::NUM_BANKS-1:0] req
    );
        logic [sched_pkg::BANK_IDX_BITS-1:0] idx;
        idx = '0;
        for (int b = sched_pkg::NUM_BANKS - 1; b >= 0; b--) begin
            if (req[b]) idx = b[sched_pkg::BANK_IDX_BITS-1:0];
        end
        return idx;
    endfunction

    // what each bank head needs next
    always_comb begin
        for (int b = 0; b < sched_pkg::NUM_BANKS; b++) begin
            ready[b]    = !empty[b] && !busy[b];
            row_hit[b]  = open[b] && (open_row[b] == head_row[b]);
            need_rd[b]  = ready[b] && row_hit[b] && !head_write[b];
            need_wr[b]  = ready[b] && row_hit[b] && head_write[b];
            need_act[b] = ready[b] && !open[b];
            need_pre[b] = ready[b] && open[b] && !row_hit[b]; // row conflict
        end
    end

    assign gap_ok = (gap_cnt >= sched_pkg::RW_GAP[sched_pkg::GAP_BITS-1:0]);

    // read, write, activate, precharge; lowest bank wins within a type
    always_comb begin
        pick_cmd   = sched_pkg::CMD_READ;
        pick_bank  = '0;
        pick_valid = cmd_ready;
        if (gap_ok && (|need_rd)) begin
            pick_bank = lowest(need_rd);
        end else if (bursting) begin
            pick_valid = 1'b0; // reads only during a burst
        end else if (gap_ok && (|need_wr)) begin
            pick_cmd  = sched_pkg::CMD_WRITE;
            pick_bank = lowest(need_wr);
        end else if (|need_act) begin
            pick_cmd  = sched_pkg::CMD_ACTIVATE;
            pick_bank = lowest(need_act);
        end else if (|need_pre) begin
            pick_cmd  = sched_pkg::CMD_PRECHARGE;
            pick_bank = lowest(need_pre);
        end else begin
            pick_valid = 1'b0;
        end
    end

    assign col_issue = pick_valid &&
        ((pick_cmd == sched_pkg::CMD_READ) || (pick_cmd == sched_pkg::CMD_WRITE));

    // pop and bank updates happen at the same edge as the output register
    always_comb begin
        deq = '0;
        act = '0;
        pre = '0;
        deq[pick_bank] = col_issue;
        act[pick_bank] = pick_valid && (pick_cmd == sched_pkg::CMD_ACTIVATE);
        pre[pick_bank] = pick_valid && (pick_cmd == sched_pkg::CMD_PRECHARGE);
    end

    assign act_row = head_row[pick_bank];

    always_comb begin
        next_addr = '0; // pad bits stay zero
        if (pick_cmd == sched_pkg::CMD_ACTIVATE) begin
            next_addr.row_view.code  = sched_pkg::CTRL_ACTIVATE;
            next_addr.row_view.group = pick_bank[sched_pkg::BANK_IDX_BITS-1 -: sched_pkg::GROUP_BITS];
            next_addr.row_view.bank  = pick_bank[sched_pkg::BANK_BITS-1:0];
            next_addr.row_view.row   = head_row[pick_bank];
        end else begin
            case (pick_cmd)
                sched_pkg::CMD_WRITE: next_addr.col_view.code = sched_pkg::CTRL_WRITE;
                sched_pkg::CMD_PRECHARGE: next_addr.col_view.code = sched_pkg::CTRL_PRECHARGE;
                default: next_addr.col_view.code = sched_pkg::CTRL_READ;
            endcase
            next_addr.col_view.group = pick_bank[sched_pkg::BANK_IDX_BITS-1 -: sched_pkg::GROUP_BITS];
            next_addr.col_view.bank  = pick_bank[sched_pkg::BANK_BITS-1:0];
            next_addr.col_view.col   = head_col[pick_bank];
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            valid_out <= 1'b0;
            cmd_out   <= '0;
            addr_out  <= '0;
            val_out   <= '0;
            gap_cnt   <= sched_pkg::RW_GAP[sched_pkg::GAP_BITS-1:0]; // first column cmd may go at once
        end else begin
            valid_out <= pick_valid;
            if (pick_valid) begin
                cmd_out  <= pick_cmd; // held between pulses
                addr_out <= next_addr;
            end
            val_out <= (pick_valid && (pick_cmd == sched_pkg::CMD_WRITE)) ?
                       head_data[pick_bank] : '0;
            if (col_issue) begin
                gap_cnt <= {{(sched_pkg::GAP_BITS-1){1'b0}}, 1'b1};
            end else if (!gap_ok) begin
                gap_cnt <= gap_cnt + 1'b1;
            end
        end
    end

endmodule

/* project.f */
sched_pkg.sv
request_router.sv
bank_queue.sv
bank_tracker.sv
command_arbiter.sv
request_scheduler.sv
tb_request_scheduler.sv

/* request_router.sv */
`timescale 1ns/1ps

module request_router (
    input  logic [sched_pkg::REQ_ADDR_BITS-1:0] mem_bus_addr_in,
    input  logic                                valid_in,
    input  logic                                write_in,
    input  logic [sched_pkg::DATA_BITS-1:0]     val_in,
    input  logic [sched_pkg::NUM_BANKS-1:0]     full,
    output logic [sched_pkg::NUM_BANKS-1:0]     enq,
    output logic [sched_pkg::ROW_BITS-1:0]      entry_row,
    output logic [sched_pkg::COL_BITS-1:0]      entry_col,
    output logic                                entry_write,
    output logic [sched_pkg::DATA_BITS-1:0]     entry_data,
    output logic                                req_full
);

    logic [sched_pkg::GROUP_BITS-1:0]    req_group;
    logic [sched_pkg::BANK_BITS-1:0]     req_bank;
    logic [sched_pkg::BANK_IDX_BITS-1:0] bank_idx;
    logic                                accept;

    // address fields
    assign entry_col = mem_bus_addr_in[sched_pkg::COL_BITS-1:0];
    assign req_bank  = mem_bus_addr_in[sched_pkg::BANK_LSB +: sched_pkg::BANK_BITS];
    assign req_group = mem_bus_addr_in[sched_pkg::GROUP_LSB +: sched_pkg::GROUP_BITS];
    assign entry_row = mem_bus_addr_in[sched_pkg::ROW_LSB +: sched_pkg::ROW_BITS];

    assign bank_idx = {req_group, req_bank}; // flat index, group * 2 + bank

    assign entry_write = write_in;
    assign entry_data  = val_in;

    // a single full bank stalls every request, the source sees one level
    assign req_full = |full;
    assign accept   = valid_in && !req_full;

    always_comb begin
        enq           = '0;
        enq[bank_idx] = accept;
    end

endmodule

/* request_scheduler.sv */
`timescale 1ns/1ps

module request_scheduler (
    input  logic                                clk_in,
    input  logic                                rst_in,
    input  logic [sched_pkg::REQ_ADDR_BITS-1:0] mem_bus_addr_in,
    input  logic                                valid_in,
    input  logic                                write_in,
    input  logic [sched_pkg::DATA_BITS-1:0]     val_in,
    input  logic                                cmd_ready,
    input  logic                                bursting,
    output logic                                req_full,
    output logic                                valid_out,
    output logic [sched_pkg::CMD_BITS-1:0]      cmd_out,
    output sched_pkg::cmd_addr_u                addr_out,
    output logic [sched_pkg::DATA_BITS-1:0]     val_out
);

    // router to queues
    logic [sched_pkg::NUM_BANKS-1:0] enq, full, empty, deq;
    logic [sched_pkg::ROW_BITS-1:0]  entry_row;
    logic [sched_pkg::COL_BITS-1:0]  entry_col;
    logic                            entry_write;
    logic [sched_pkg::DATA_BITS-1:0] entry_data;

    // queue heads
    logic [sched_pkg::NUM_BANKS-1:0][sched_pkg::ROW_BITS-1:0]  head_row;
    logic [sched_pkg::NUM_BANKS-1:0][sched_pkg::COL_BITS-1:0]  head_col;
    logic [sched_pkg::NUM_BANKS-1:0]                           head_write;
    logic [sched_pkg::NUM_BANKS-1:0][sched_pkg::DATA_BITS-1:0] head_data;

    // arbiter and bank state
    logic [sched_pkg::NUM_BANKS-1:0]                          act, pre, open, busy;
    logic [sched_pkg::ROW_BITS-1:0]                           act_row;
    logic [sched_pkg::NUM_BANKS-1:0][sched_pkg::ROW_BITS-1:0] open_row;

    request_router u_request_router (
        .mem_bus_addr_in(mem_bus_addr_in), .valid_in(valid_in), .write_in(write_in),
        .val_in(val_in), .full(full), .enq(enq), .entry_row(entry_row),
        .entry_col(entry_col), .entry_write(entry_write), .entry_data(entry_data),
        .req_full(req_full)
    );

    for (genvar b = 0; b < sched_pkg::NUM_BANKS; b++) begin : g_bank
        bank_queue u_bank_queue (
            .clk_in(clk_in), .rst_in(rst_in), .enq(enq[b]), .deq(deq[b]),
            .in_row(entry_row), .in_col(entry_col), .in_write(entry_write),
            .in_data(entry_data), .full(full[b]), .empty(empty[b]),
            .head_row(head_row[b]), .head_col(head_col[b]),
            .head_write(head_write[b]), .head_data(head_data[b])
        );
    end

    bank_tracker u_bank_tracker (
        .clk_in(clk_in), .rst_in(rst_in), .act(act), .pre(pre), .act_row(act_row),
        .open(open), .open_row(open_row), .busy(busy)
    );

    command_arbiter u_command_arbiter (
        .clk_in(clk_in), .rst_in(rst_in), .cmd_ready(cmd_ready), .bursting(bursting),
        .empty(empty), .head_row(head_row), .head_col(head_col),
        .head_write(head_write), .head_data(head_data), .open(open),
        .open_row(open_row), .busy(busy), .deq(deq), .act(act), .pre(pre),
        .act_row(act_row), .valid_out(valid_out), .cmd_out(cmd_out),
        .addr_out(addr_out), .val_out(val_out)
    );

endmodule

/* sched_pkg.sv */
package sched_pkg;

    // bank geometry, 2 groups of 2 banks
    localparam int GROUP_BITS    = 1;
    localparam int BANK_BITS     = 1;
    localparam int NUM_BANKS     = 4;
    localparam int BANK_IDX_BITS = GROUP_BITS + BANK_BITS; // group * 2 + bank

    localparam int ROW_BITS  = 8;
    localparam int COL_BITS  = 4;
    localparam int DATA_BITS = 32;

    // request address, low to high: column, bank, group, row
    localparam int REQ_ADDR_BITS = 14;
    localparam int BANK_LSB      = COL_BITS;
    localparam int GROUP_LSB     = BANK_LSB + BANK_BITS;
    localparam int ROW_LSB       = GROUP_LSB + GROUP_BITS;

    localparam int QUEUE_DEPTH = 4; // entries per bank
    localparam int QPTR_BITS   = $clog2(QUEUE_DEPTH);

    // bank timing, in cycles
    localparam int ACT_LATENCY = 8;
    localparam int PRE_LATENCY = 5;
    localparam int TIMER_BITS  = $clog2(ACT_LATENCY + 1);
    localparam int RW_GAP      = 4; // min distance between column commands
    localparam int GAP_BITS    = $clog2(RW_GAP + 1);

    // command codes on cmd_out
    localparam int CMD_BITS = 3;
    localparam logic [CMD_BITS-1:0] CMD_READ      = 3'd0;
    localparam logic [CMD_BITS-1:0] CMD_WRITE     = 3'd1;
    localparam logic [CMD_BITS-1:0] CMD_ACTIVATE  = 3'd2;
    localparam logic [CMD_BITS-1:0] CMD_PRECHARGE = 3'd3;

    // control field in the top bits of the command word
    localparam int CMD_ADDR_BITS = 19;
    localparam int CTRL_BITS     = 5;
    localparam logic [CTRL_BITS-1:0] CTRL_ACTIVATE  = 5'b00000;
    localparam logic [CTRL_BITS-1:0] CTRL_WRITE     = 5'b01100;
    localparam logic [CTRL_BITS-1:0] CTRL_READ      = 5'b01101;
    localparam logic [CTRL_BITS-1:0] CTRL_PRECHARGE = 5'b01010;

    localparam int ROW_PAD_BITS = CMD_ADDR_BITS - CTRL_BITS - BANK_IDX_BITS - ROW_BITS;
    localparam int COL_PAD_BITS = CMD_ADDR_BITS - CTRL_BITS - BANK_IDX_BITS - COL_BITS;

    // one command word, seen with a row or with a column in the low bits
    typedef union packed {
        struct packed {
            logic [CTRL_BITS-1:0]    code;
            logic [GROUP_BITS-1:0]   group;
            logic [BANK_BITS-1:0]    bank;
            logic [ROW_PAD_BITS-1:0] pad;
            logic [ROW_BITS-1:0]     row;
        } row_view; // activate

        struct packed {
            logic [CTRL_BITS-1:0]    code;
            logic [GROUP_BITS-1:0]   group;
            logic [BANK_BITS-1:0]    bank;
            logic [COL_PAD_BITS-1:0] pad;
            logic [COL_BITS-1:0]     col;
        } col_view; // read, write, precharge
    } cmd_addr_u;

endpackage

/* tb_request_scheduler.sv */
`timescale 1ns/1ps

module tb_request_scheduler;

    localparam int STIM_CYCLES = 3000;
    localparam int DRAIN_LIMIT = 2000;
    // expected entry, high to low: bank index, write flag, row, column, data
    localparam int COL_POS    = sched_pkg::DATA_BITS;
    localparam int ROW_POS    = COL_POS + sched_pkg::COL_BITS;
    localparam int WR_POS     = ROW_POS + sched_pkg::ROW_BITS;
    localparam int ENTRY_BITS = WR_POS + 1 + sched_pkg::BANK_IDX_BITS;

    logic                                clk_in = 1'b0;
    logic                                rst_in;
    logic [sched_pkg::REQ_ADDR_BITS-1:0] mem_bus_addr_in;
    logic                                valid_in;
    logic                                write_in;
    logic [sched_pkg::DATA_BITS-1:0]     val_in;
    logic                                cmd_ready;
    logic                                bursting;
    logic                                req_full;
    logic                                valid_out;
    logic [sched_pkg::CMD_BITS-1:0]      cmd_out;
    sched_pkg::cmd_addr_u                addr_out;
    logic [sched_pkg::DATA_BITS-1:0]     val_out;

    logic [ENTRY_BITS-1:0]           exp_q [$]; // accepted requests, oldest first
    logic [sched_pkg::NUM_BANKS-1:0] model_open;
    logic [sched_pkg::ROW_BITS-1:0]  model_row [sched_pkg::NUM_BANKS];
    int last_act [sched_pkg::NUM_BANKS];
    int last_pre [sched_pkg::NUM_BANKS];
    int last_col, cycle, value_errors, protocol_errors, timeout_errors, accepted, completed;
    logic prev_ready, prev_burst, full_seen, released;

    request_scheduler u_request_scheduler (
        .clk_in(clk_in), .rst_in(rst_in), .mem_bus_addr_in(mem_bus_addr_in),
        .valid_in(valid_in), .write_in(write_in), .val_in(val_in),
        .cmd_ready(cmd_ready), .bursting(bursting), .req_full(req_full),
        .valid_out(valid_out), .cmd_out(cmd_out), .addr_out(addr_out), .val_out(val_out)
    );

    always #2 clk_in = ~clk_in;

    task automatic check_cmd(input string name, input logic [sched_pkg::CMD_BITS-1:0] got,
                             input logic [sched_pkg::CMD_BITS-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input sched_pkg::cmd_addr_u got,
                              input sched_pkg::cmd_addr_u exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input logic [sched_pkg::DATA_BITS-1:0] got,
                              input logic [sched_pkg::DATA_BITS-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic protocol_error(input string what);
        protocol_errors++;
        $display("%0t protocol violation: %s", $time, what);
    endtask

    // control field of the command word for each command
    function automatic logic [4:0] ctrl_code(input logic [sched_pkg::CMD_BITS-1:0] cmd);
        case (cmd)
            sched_pkg::CMD_READ:     return 5'b01101;
            sched_pkg::CMD_WRITE:    return 5'b01100;
            sched_pkg::CMD_ACTIVATE: return 5'b00000;
            default:                 return 5'b01010;
        endcase
    endfunction

    // oldest pending request of a bank, -1 if none
    function automatic int find_head(input int bank);
        for (int i = 0; i < exp_q.size(); i++) begin
            if (exp_q[i][ENTRY_BITS-1 -: sched_pkg::BANK_IDX_BITS] == bank) return i;
        end
        return -1;
    endfunction

    // requests still held for one bank
    function automatic int pending_count(input int bank);
        int n;
        n = 0;
        for (int i = 0; i < exp_q.size(); i++) begin
            if (exp_q[i][ENTRY_BITS-1 -: sched_pkg::BANK_IDX_BITS] == bank) n++;
        end
        return n;
    endfunction

    task automatic handle_pulse();
        sched_pkg::cmd_addr_u           exp_addr;
        logic [sched_pkg::CMD_BITS-1:0] exp_cmd;
        logic [ENTRY_BITS-1:0]          entry;
        int                             bank;
        int                             idx;
        bank     = addr_out.col_view.group * 2 + addr_out.col_view.bank;
        idx      = find_head(bank);
        entry    = (idx >= 0) ? exp_q[idx] : '0;
        exp_addr = '0;
        exp_addr.col_view.group = 1'(bank / 2);
        exp_addr.col_view.bank  = 1'(bank % 2);
        if (cmd_out > sched_pkg::CMD_PRECHARGE) begin
            protocol_error($sformatf("unknown command code %0d", cmd_out));
        end else if (idx < 0) begin
            protocol_error($sformatf("command %0d to bank %0d with no pending request",
                                     cmd_out, bank));
        end else if (cmd_out == sched_pkg::CMD_ACTIVATE) begin
            exp_addr.row_view.code = ctrl_code(sched_pkg::CMD_ACTIVATE);
            exp_addr.row_view.row  = entry[ROW_POS +: sched_pkg::ROW_BITS];
            check_addr("addr_out", addr_out, exp_addr);
            check_data("val_out", val_out, '0);
            if (model_open[bank]) protocol_error($sformatf("activate to open bank %0d", bank));
            if (cycle - last_pre[bank] < sched_pkg::PRE_LATENCY)
                protocol_error($sformatf("activate too soon after precharge, bank %0d", bank));
            model_open[bank] = 1'b1;
            model_row[bank]  = addr_out.row_view.row;
            last_act[bank]   = cycle;
        end else if (cmd_out == sched_pkg::CMD_PRECHARGE) begin
            exp_addr.col_view.code = ctrl_code(sched_pkg::CMD_PRECHARGE);
            exp_addr.col_view.col  = entry[COL_POS +: sched_pkg::COL_BITS]; // head's column
            check_addr("addr_out", addr_out, exp_addr);
            check_data("val_out", val_out, '0);
            if (!model_open[bank]) protocol_error($sformatf("precharge to closed bank %0d", bank));
            model_open[bank] = 1'b0;
            last_pre[bank]   = cycle;
        end else begin
            exp_cmd = entry[WR_POS] ? sched_pkg::CMD_WRITE : sched_pkg::CMD_READ;
            check_cmd("cmd_out", cmd_out, exp_cmd);
            exp_addr.col_view.code = ctrl_code(exp_cmd);
            exp_addr.col_view.col  = entry[COL_POS +: sched_pkg::COL_BITS];
            check_addr("addr_out", addr_out, exp_addr);
            check_data("val_out", val_out, entry[WR_POS] ? entry[sched_pkg::DATA_BITS-1:0] : '0);
            if (!model_open[bank] || model_row[bank] !== entry[ROW_POS +: sched_pkg::ROW_BITS])
                protocol_error($sformatf("column command without its row open, bank %0d", bank));
            if (cycle - last_act[bank] < sched_pkg::ACT_LATENCY)
                protocol_error($sformatf("column command too soon after activate, bank %0d", bank));
            if (cycle - last_col < sched_pkg::RW_GAP)
                protocol_error("column commands closer than the minimum gap");
            last_col = cycle;
            exp_q.delete(idx);
            completed++;
        end
    endtask

    // outputs and accepted requests are sampled mid-cycle, away from the edges
    always @(negedge clk_in) begin : monitor
        logic exp_full;
        cycle++;
        if (rst_in) begin
            if (valid_out !== 1'b0) protocol_error("valid_out high during reset");
            prev_ready = 1'b0;
            prev_burst = 1'b0;
        end else begin
            if (!released && valid_out !== 1'b0)
                protocol_error("valid_out high in the first cycle after reset");
            released = 1'b1;
            if (valid_out === 1'b1) begin
                if (!prev_ready) protocol_error("command issued after an edge with cmd_ready low");
                if (prev_burst && cmd_out !== sched_pkg::CMD_READ)
                    protocol_error("command other than read issued while bursting");
                handle_pulse();
            end else begin
                check_data("val_out", val_out, '0);
            end
            // occupancy after the last edge, pops of this pulse already removed
            exp_full = 1'b0;
            for (int b = 0; b < sched_pkg::NUM_BANKS; b++) begin
                if (pending_count(b) == sched_pkg::QUEUE_DEPTH) exp_full = 1'b1;
            end
            check_flag("req_full", req_full, exp_full);
            if (valid_in && !req_full) begin
                exp_q.push_back({2'(mem_bus_addr_in[5] * 2 + mem_bus_addr_in[4]), write_in,
                                 mem_bus_addr_in[13:6], mem_bus_addr_in[3:0], val_in});
                accepted++;
            end
            prev_ready = cmd_ready;
            prev_burst = bursting;
        end
        full_seen = req_full;
    end

    initial begin
        int waited;
        logic [sched_pkg::ROW_BITS-1:0] row;
        void'($urandom(92));
        rst_in = 1'b1;
        mem_bus_addr_in = '0;
        valid_in = 1'b0;
        write_in = 1'b0;
        val_in = '0;
        cmd_ready = 1'b0;
        bursting = 1'b0;
        model_open = '0;
        for (int b = 0; b < sched_pkg::NUM_BANKS; b++) begin
            last_act[b] = -1000;
            last_pre[b] = -1000;
        end
        last_col = -1000;
        full_seen = 1'b0;
        released = 1'b0;
        repeat (10) @(posedge clk_in);
        rst_in <= 1'b0;
        for (int i = 0; i < STIM_CYCLES; i++) begin
            @(posedge clk_in);
            row = 8'h30 + 8'($urandom % 3); // few rows, many conflicts
            valid_in        <= (($urandom % 100) < 30) && !full_seen;
            write_in        <= 1'($urandom % 2);
            val_in          <= $urandom;
            mem_bus_addr_in <= {row, 2'($urandom % 4), 4'($urandom % 16)};
            cmd_ready       <= ($urandom % 100) < 70;
            bursting        <= ($urandom % 100) < 10;
        end
        @(posedge clk_in);
        valid_in  <= 1'b0;
        cmd_ready <= 1'b1;
        bursting  <= 1'b0;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk_in);
            waited++;
        end
        if (exp_q.size() != 0) begin
            timeout_errors++;
            $display("timeout: %0d requests never completed during drain", exp_q.size());
        end
        $display("errors: %0d value, %0d protocol, %0d timeout (%0d accepted, %0d completed)",
                 value_errors, protocol_errors, timeout_errors, accepted, completed);
        if (value_errors + protocol_errors + timeout_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
